/* hdl/aes_consts.svh */
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

`define WB_DW 32
`define WB_AW 32

// register map, word indices
`define REG_CTRL 0 // bit 0 start
`define REG_PT0  1 // msw of plaintext
`define REG_KEY0 5 // msw of key
`define REG_STAT 9 // bit 0 ct_valid
`define REG_CT0  10
`define REG_LAST 13

`endif

/* hdl/wb_bus_pkg.sv */
`include "aes_consts.svh"

package wb_bus_pkg;

   // bus address, byte granular
   typedef logic [`WB_AW-1:0] wb_adr_t;

   typedef logic [`WB_DW-1:0] wb_dat_t;

   // one bit per byte lane
   typedef logic [`WB_DW/8-1:0] wb_sel_t;

endpackage

/* hdl/aes_pkg.sv */
package aes_pkg;

   typedef logic [7:0]   aes_byte_t;
   typedef logic [31:0]  aes_word_t;  // one state column
   typedef logic [127:0] aes_block_t; // state, key or ciphertext
   typedef logic [3:0]   aes_rnd_t;

   typedef enum logic {
      CORE_IDLE,
      CORE_RUN
   } aes_core_st_t;

   // multiply by x in GF(2^8), poly 0x11b
   function automatic aes_byte_t xtime(input aes_byte_t a);
      aes_byte_t r;
      r = {a[6:0], 1'b0};
      if (a[7])
         r = r ^ 8'h1b;
      return r;
   endfunction

endpackage

/* hdl/aes_sbox.sv */
`timescale 1ns/1ps

module aes_sbox (
   input  aes_pkg::aes_byte_t in_i,
   output aes_pkg::aes_byte_t out_o
);

   import aes_pkg::*;

   aes_byte_t x2;
   aes_byte_t x3;
   aes_byte_t x6;
   aes_byte_t x12;
   aes_byte_t x15;
   aes_byte_t x30;
   aes_byte_t x60;
   aes_byte_t x120;
   aes_byte_t x240;
   aes_byte_t x252;
   aes_byte_t inv;

   function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
      aes_byte_t p;
      aes_byte_t t;
      p = '0;
      t = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i])
            p = p ^ t;
         t = xtime(t);
      end
      return p;
   endfunction

   // inverse as x^254
   assign x2   = gf_mul(in_i, in_i);
   assign x3   = gf_mul(x2, in_i);
   assign x6   = gf_mul(x3, x3);
   assign x12  = gf_mul(x6, x6);
   assign x15  = gf_mul(x12, x3);
   assign x30  = gf_mul(x15, x15);
   assign x60  = gf_mul(x30, x30);
   assign x120 = gf_mul(x60, x60);
   assign x240 = gf_mul(x120, x120);
   assign x252 = gf_mul(x240, x12);
   assign inv  = gf_mul(x252, x2); // 0 stays 0

   // affine transform
   assign out_o = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

/* hdl/aes_key_expand.sv */
`timescale 1ns/1ps

module aes_key_expand (
   input  aes_pkg::aes_block_t key_i,
   input  aes_pkg::aes_byte_t  rcon_i,
   output aes_pkg::aes_block_t key_o,
   output aes_pkg::aes_byte_t  rcon_o
);

   import aes_pkg::*;

   aes_word_t w0;
   aes_word_t w1;
   aes_word_t w2;
   aes_word_t w3;
   aes_word_t rot;
   aes_word_t sub;
   aes_word_t tmp;
   aes_word_t n0;
   aes_word_t n1;
   aes_word_t n2;
   aes_word_t n3;

   assign w0 = key_i[127:96];
   assign w1 = key_i[95:64];
   assign w2 = key_i[63:32];
   assign w3 = key_i[31:0];

   assign rot = {w3[23:0], w3[31:24]}; // RotWord

   // SubWord
   for (genvar b = 0; b < 4; b++) begin : g_sub
      aes_sbox u_sbox (
         .in_i  (rot[8*b +: 8]),
         .out_o (sub[8*b +: 8])
      );
   end

   assign tmp = sub ^ {rcon_i, 24'h000000};

   // chained xor through the words
   assign n0 = w0 ^ tmp;
   assign n1 = w1 ^ n0;
   assign n2 = w2 ^ n1;
   assign n3 = w3 ^ n2;

   assign key_o  = {n0, n1, n2, n3};
   assign rcon_o = xtime(rcon_i); // 0x80 wraps to 0x1b

endmodule

/* hdl/aes_round.sv */
`timescale 1ns/1ps

module aes_round (
   input  aes_pkg::aes_block_t state_i,
   input  aes_pkg::aes_block_t round_key_i,
   input  logic                final_i,
   output aes_pkg::aes_block_t state_o
);

   import aes_pkg::*;

   // byte k sits at bits 127-8k, column k/4, row k%4
   aes_byte_t  sb [16];
   aes_byte_t  sr [16];
   aes_byte_t  mc [16];
   aes_block_t sr_blk;
   aes_block_t mc_blk;
   aes_block_t mixed;

   // SubBytes
   for (genvar k = 0; k < 16; k++) begin : g_sbox
      aes_sbox u_sbox (
         .in_i  (state_i[127-8*k -: 8]),
         .out_o (sb[k])
      );
   end

   for (genvar c = 0; c < 4; c++) begin : g_col
      aes_byte_t a0;
      aes_byte_t a1;
      aes_byte_t a2;
      aes_byte_t a3;

      // ShiftRows, row r moves left by r
      for (genvar r = 0; r < 4; r++) begin : g_row
         assign sr[4*c+r] = sb[4*((c+r)%4)+r];
      end

      assign a0 = sr[4*c];
      assign a1 = sr[4*c+1];
      assign a2 = sr[4*c+2];
      assign a3 = sr[4*c+3];

      // MixColumns
      assign mc[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      assign mc[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      assign mc[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      assign mc[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
   end

   for (genvar k = 0; k < 16; k++) begin : g_pack
      assign sr_blk[127-8*k -: 8] = sr[k];
      assign mc_blk[127-8*k -: 8] = mc[k];
   end

   assign mixed = final_i ? sr_blk : mc_blk; // last round has no MixColumns

   // AddRoundKey
   assign state_o = mixed ^ round_key_i;

endmodule

/* hdl/aes_128.sv */
`timescale 1ns/1ps

`include "aes_consts.svh"

module aes_128 (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  aes_pkg::aes_block_t state_i,
   input  aes_pkg::aes_block_t key_i,
   input  logic                start_i,
   output aes_pkg::aes_block_t ct_o,
   output logic                ct_valid_o,
   output logic                done_o
);

   import aes_pkg::*;

   aes_core_st_t st_q;
   aes_block_t   state_q;
   aes_block_t   rkey_q;
   aes_block_t   next_key;
   aes_block_t   next_state;
   aes_byte_t    rcon_q;
   aes_byte_t    next_rcon;
   aes_rnd_t     rnd_q;
   logic         start_q;
   logic         start_d;
   logic         start_edge;
   logic         last_rnd;
   logic         valid_q;
   logic         done_q;

   assign start_edge = start_q & ~start_d;
   assign last_rnd   = (rnd_q == aes_rnd_t'(`AES_ROUNDS));

   aes_key_expand u_key_expand (
      .key_i  (rkey_q),
      .rcon_i (rcon_q),
      .key_o  (next_key),
      .rcon_o (next_rcon)
   );

   aes_round u_round (
      .state_i     (state_q),
      .round_key_i (next_key),
      .final_i     (last_rnd),
      .state_o     (next_state)
   );

   // start level sampled twice for the edge
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_q <= 1'b0;
         start_d <= 1'b0;
      end else begin
         start_q <= start_i;
         start_d <= start_q;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         st_q    <= CORE_IDLE;
         state_q <= '0;
         rkey_q  <= '0;
         rcon_q  <= '0;
         rnd_q   <= '0;
         valid_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (st_q)
            CORE_IDLE: begin
               if (start_edge) begin
                  state_q <= state_i ^ key_i; // initial AddRoundKey
                  rkey_q  <= key_i;
                  rcon_q  <= 8'h01;
                  rnd_q   <= 4'd1;
                  valid_q <= 1'b0;
                  st_q    <= CORE_RUN;
               end
            end
            CORE_RUN: begin // edges here are dropped
               state_q <= next_state;
               rkey_q  <= next_key;
               rcon_q  <= next_rcon;
               rnd_q   <= rnd_q + 4'd1;
               if (last_rnd) begin
                  valid_q <= 1'b1;
                  done_q  <= 1'b1;
                  st_q    <= CORE_IDLE;
               end
            end
            default: st_q <= CORE_IDLE;
         endcase
      end
   end

   assign ct_o       = state_q; // held until next load
   assign ct_valid_o = valid_q;
   assign done_o     = done_q;

endmodule

/* hdl/aes_top.sv */
`timescale 1ns/1ps

`include "aes_consts.svh"

module aes_top (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  wb_bus_pkg::wb_adr_t wb_adr_i,
   input  wb_bus_pkg::wb_dat_t wb_dat_i,
   input  wb_bus_pkg::wb_sel_t wb_sel_i,
   input  logic                wb_we_i,
   input  logic                wb_stb_i,
   input  logic                wb_cyc_i,
   output wb_bus_pkg::wb_dat_t wb_dat_o,
   output logic                wb_ack_o,
   output logic                wb_err_o,
   output logic                int_o
);

   import wb_bus_pkg::*;
   import aes_pkg::*;

   logic [3:0] idx;
   logic [1:0] pt_off;
   logic [1:0] key_off;
   logic [1:0] ct_off;
   logic       mapped;
   logic       is_pt;
   logic       is_key;
   logic       access;
   logic       wr_en;
   logic       start_q;
   logic       ct_valid;
   aes_word_t  pt_q [4];  // [0] is the msw
   aes_word_t  key_q [4];
   aes_block_t pt_blk;
   aes_block_t key_blk;
   aes_block_t ct;
   wb_dat_t    rd_dat;

   function automatic wb_dat_t lane_merge(input wb_dat_t old_v, input wb_dat_t new_v,
                                          input wb_sel_t sel);
      wb_dat_t r;
      r = old_v;
      for (int b = 0; b < `WB_DW/8; b++) begin
         if (sel[b])
            r[8*b +: 8] = new_v[8*b +: 8];
      end
      return r;
   endfunction

   // address decode
   assign idx     = wb_adr_i[5:2];
   assign mapped  = (wb_adr_i[`WB_AW-1:6] == '0) && (idx <= 4'(`REG_LAST));
   assign is_pt   = (idx >= 4'(`REG_PT0)) && (idx < 4'(`REG_KEY0));
   assign is_key  = (idx >= 4'(`REG_KEY0)) && (idx < 4'(`REG_STAT));
   assign pt_off  = 2'(idx - 4'(`REG_PT0));
   assign key_off = 2'(idx - 4'(`REG_KEY0));
   assign ct_off  = 2'(idx - 4'(`REG_CT0));

   assign access   = wb_cyc_i & wb_stb_i;
   assign wb_ack_o = access & mapped;
   assign wb_err_o = access & ~mapped;
   assign wr_en    = wb_ack_o & wb_we_i;

   // write side, status and ciphertext are read-only
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_q <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            pt_q[i]  <= '0;
            key_q[i] <= '0;
         end
      end else if (wr_en) begin
         if (idx == 4'(`REG_CTRL)) begin
            if (wb_sel_i[0])
               start_q <= wb_dat_i[0];
         end else if (is_pt) begin
            pt_q[pt_off] <= lane_merge(pt_q[pt_off], wb_dat_i, wb_sel_i);
         end else if (is_key) begin
            key_q[key_off] <= lane_merge(key_q[key_off], wb_dat_i, wb_sel_i);
         end
      end
   end

   // read side, zero when unmapped
   always_comb begin
      rd_dat = '0;
      if (mapped) begin
         if (idx == 4'(`REG_CTRL))
            rd_dat[0] = start_q;
         else if (is_pt)
            rd_dat = pt_q[pt_off];
         else if (is_key)
            rd_dat = key_q[key_off];
         else if (idx == 4'(`REG_STAT))
            rd_dat[0] = ct_valid;
         else
            rd_dat = ct[(3 - ct_off) * 32 +: 32]; // msw first
      end
   end

   assign wb_dat_o = rd_dat;

   assign pt_blk  = {pt_q[0], pt_q[1], pt_q[2], pt_q[3]};
   assign key_blk = {key_q[0], key_q[1], key_q[2], key_q[3]};

   aes_128 u_aes (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .state_i    (pt_blk),
      .key_i      (key_blk),
      .start_i    (start_q),
      .ct_o       (ct),
      .ct_valid_o (ct_valid),
      .done_o     (int_o)     // one pulse per block
   );

endmodule

/* tests/tb_aes_model.svh */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

logic [7:0] sbox_tab [256];

function automatic logic [7:0] gf_double(input logic [7:0] a);
   return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] gf_product(input logic [7:0] a, input logic [7:0] b);
   logic [7:0] p;
   logic [7:0] t;
   p = 8'h00;
   t = a;
   for (int i = 0; i < 8; i++) begin
      if (b[i])
         p = p ^ t;
      t = gf_double(t);
   end
   return p;
endfunction

// inverse by search, then the affine map bit by bit
function automatic logic [7:0] sbox_calc(input logic [7:0] a);
   logic [7:0] inv;
   logic [7:0] s;
   logic [7:0] aff;
   inv = 8'h00;
   aff = 8'h63;
   for (int y = 1; y < 256; y++) begin
      if (gf_product(a, 8'(y)) == 8'h01)
         inv = 8'(y);
   end
   for (int i = 0; i < 8; i++) begin
      s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8] ^ aff[i];
   end
   return s;
endfunction

task automatic fill_sbox_table();
   for (int a = 0; a < 256; a++)
      sbox_tab[a] = sbox_calc(8'(a));
endtask

function automatic logic [127:0] aes_encrypt(input logic [127:0] pt, input logic [127:0] key);
   logic [31:0]  w [44];
   logic [7:0]   s [16];
   logic [7:0]   t [16];
   logic [31:0]  tmp;
   logic [7:0]   rc;
   logic [7:0]   b0;
   logic [7:0]   b1;
   logic [7:0]   b2;
   logic [7:0]   b3;
   logic [127:0] res;
   rc = 8'h01;
   for (int i = 0; i < 4; i++)
      w[i] = key[127-32*i -: 32];
   for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin
         tmp = {sbox_tab[tmp[23:16]], sbox_tab[tmp[15:8]], sbox_tab[tmp[7:0]],
                sbox_tab[tmp[31:24]]} ^ {rc, 24'h000000};
         rc  = gf_double(rc);
      end
      w[i] = w[i-4] ^ tmp;
   end
   for (int k = 0; k < 16; k++)
      s[k] = pt[127-8*k -: 8] ^ key[127-8*k -: 8];
   for (int r = 1; r <= 10; r++) begin
      for (int c = 0; c < 4; c++) begin
         for (int row = 0; row < 4; row++)
            t[4*c+row] = sbox_tab[s[4*((c+row)%4)+row]]; // sub and shift
      end
      for (int c = 0; c < 4; c++) begin
         b0 = t[4*c];
         b1 = t[4*c+1];
         b2 = t[4*c+2];
         b3 = t[4*c+3];
         if (r < 10) begin
            s[4*c]   = gf_product(b0, 8'h02) ^ gf_product(b1, 8'h03) ^ b2 ^ b3;
            s[4*c+1] = b0 ^ gf_product(b1, 8'h02) ^ gf_product(b2, 8'h03) ^ b3;
            s[4*c+2] = b0 ^ b1 ^ gf_product(b2, 8'h02) ^ gf_product(b3, 8'h03);
            s[4*c+3] = gf_product(b0, 8'h03) ^ b1 ^ b2 ^ gf_product(b3, 8'h02);
         end else begin
            s[4*c]   = b0;
            s[4*c+1] = b1;
            s[4*c+2] = b2;
            s[4*c+3] = b3;
         end
         for (int row = 0; row < 4; row++)
            s[4*c+row] = s[4*c+row] ^ w[4*r+c][31-8*row -: 8];
      end
   end
   for (int k = 0; k < 16; k++)
      res[127-8*k -: 8] = s[k];
   return res;
endfunction

`endif

/* tests/tb_aes_top.sv */
`timescale 1ns/1ps

`include "aes_consts.svh"

module tb_aes_top;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        int_o;

   logic [31:0] rng;
   logic [31:0] regs_model [14];
   logic        last_ack;
   logic        last_err;
   logic        last_int;
   int          err_count;
   int          check_count;
   int          test_count;
   int          test_err_base;

   `include "tb_aes_model.svh"

   aes_top dut0 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .int_o    (int_o)
   );

   always #50 wb_clk_i = ~wb_clk_i;

   function automatic logic [31:0] word_addr(input int idx);
      return 32'(idx) << 2;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223; // lcg step
      return rng ^ {16'h0000, rng[31:16]};
   endfunction

   task automatic rand_block(output logic [127:0] b);
      b = '0;
      for (int i = 0; i < 4; i++)
         b = {b[95:0], next_rand()};
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      if (act !== exp) begin
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
         err_count++;
      end
   endtask

   // one access from falling edge to falling edge
   task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i  = 1'b1;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      #10;
      last_ack = wb_ack_o;
      last_err = wb_err_o;
      last_int = int_o;
      @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
      wb_adr_i = adr;
      wb_sel_i = 4'hf;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      #10;
      dat      = wb_dat_o;
      last_ack = wb_ack_o;
      last_err = wb_err_o;
      last_int = int_o;
      @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
   endtask

   task automatic check_response(input logic ack_exp);
      check("wb_ack_o", 32'(ack_exp), 32'(last_ack));
      check("wb_err_o", 32'(!ack_exp), 32'(last_err));
   endtask

   // register model follows the byte lanes
   task automatic write_reg(input int idx, input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      bus_write(word_addr(idx), dat, sel);
      check_response(1'b1);
      if (idx == `REG_CTRL && sel[0])
         regs_model[idx] = {31'b0, dat[0]};
      else if (idx >= `REG_PT0 && idx < `REG_STAT)
         regs_model[idx] = (regs_model[idx] & ~mask) | (dat & mask);
   endtask

   task automatic compare_all_regs();
      logic [31:0] d;
      for (int i = 0; i <= `REG_LAST; i++) begin
         bus_read(word_addr(i), d);
         check_response(1'b1);
         check($sformatf("reg %0d", i), regs_model[i], d);
      end
   endtask

   // edges counts clock edges since the start write
   task automatic wait_for_valid(input int edges_in, output int rise, output int pulses);
      logic [31:0] d;
      int          edges;
      int          n;
      bit          seen;
      edges  = edges_in;
      rise   = -1;
      pulses = 0;
      seen   = 1'b0;
      n      = 0;
      while (!seen && n < 100) begin
         bus_read(word_addr(`REG_STAT), d);
         if (last_int)
            pulses++;
         if (edges >= 2 && d[0]) begin
            seen = 1'b1;
            rise = edges;
         end
         edges++;
         n++;
      end
      if (!seen) begin
         $display("timeout, ct_valid did not rise within 100 cycles");
         err_count++;
      end else begin
         repeat (2) begin
            bus_read(word_addr(`REG_STAT), d);
            if (last_int)
               pulses++;
         end
      end
   endtask

   task automatic run_block(input logic [127:0] pt, input logic [127:0] key,
                            input bit restart, input logic [127:0] exp_ct);
      logic [31:0] d;
      int          edges;
      int          rise;
      int          pulses;
      for (int i = 0; i < 4; i++) begin
         write_reg(`REG_PT0 + i, pt[127-32*i -: 32], 4'hf);
         write_reg(`REG_KEY0 + i, key[127-32*i -: 32], 4'hf);
      end
      write_reg(`REG_CTRL, 32'h0, 4'hf);
      write_reg(`REG_CTRL, 32'h1, 4'hf);
      edges = 0;
      if (restart) begin // second edge lands mid run
         write_reg(`REG_CTRL, 32'h0, 4'hf);
         write_reg(`REG_CTRL, 32'h1, 4'hf);
         edges = 2;
      end
      wait_for_valid(edges, rise, pulses);
      check("ct_valid rise edge", 32'd12, 32'(rise));
      check("int_o pulses", 32'd1, 32'(pulses));
      for (int i = 0; i < 4; i++) begin
         bus_read(word_addr(`REG_CT0 + i), d);
         check($sformatf("ct word %0d", i), exp_ct[127-32*i -: 32], d);
         regs_model[`REG_CT0 + i] = exp_ct[127-32*i -: 32];
      end
      regs_model[`REG_STAT] = 32'h1;
   endtask

   task automatic report_test(input string name);
      test_count++;
      if (err_count == test_err_base)
         $display("test %0d %s: pass", test_count, name);
      else
         $display("test %0d %s: fail, %0d errors", test_count, name, err_count - test_err_base);
      test_err_base = err_count;
   endtask

   initial begin
      logic [127:0] pt;
      logic [127:0] key;
      logic [31:0]  r;
      logic [31:0]  d;
      int           idx;
      wb_clk_i      = 1'b0;
      wb_rst_i      = 1'b1;
      wb_adr_i      = '0;
      wb_dat_i      = '0;
      wb_sel_i      = 4'h0;
      wb_we_i       = 1'b0;
      wb_stb_i      = 1'b0;
      wb_cyc_i      = 1'b0;
      rng           = 32'd72143;
      err_count     = 0;
      check_count   = 0;
      test_count    = 0;
      test_err_base = 0;
      for (int i = 0; i < 14; i++)
         regs_model[i] = '0;
      fill_sbox_table();
      repeat (4) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      check("int_o", 32'd0, 32'(int_o));
      compare_all_regs();
      report_test("reset values");

      for (int n = 0; n < 60; n++) begin
         r   = next_rand();
         idx = 1 + int'(r[23:8] % 16'd13); // pt, key, status and ct words
         d   = next_rand();
         write_reg(idx, d, r[31:28]);
         bus_read(word_addr(idx), r);
         check($sformatf("reg %0d", idx), regs_model[idx], r);
      end
      compare_all_regs();
      report_test("register access");

      run_block(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f,
                1'b0, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
      report_test("fips-197 vector");

      for (int n = 0; n < 20; n++) begin
         rand_block(pt);
         rand_block(key);
         run_block(pt, key, 1'b0, aes_encrypt(pt, key));
      end
      report_test("random blocks");

      for (int n = 0; n < 8; n++) begin
         r = next_rand();
         if (n < 2) begin
            r = word_addr(14 + n);
         end else if (r[31:6] == '0) begin
            r[6] = 1'b1;
         end
         d = next_rand();
         bus_write(r, d, 4'hf);
         check_response(1'b0);
         bus_read(r, d);
         check_response(1'b0);
         check("wb_dat_o", 32'h0, d);
      end
      compare_all_regs();
      report_test("unmapped access");

      rand_block(pt);
      rand_block(key);
      run_block(pt, key, 1'b1, aes_encrypt(pt, key));
      compare_all_regs();
      report_test("start during run");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
      if (err_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* list.f */
+incdir+hdl
+incdir+tests
hdl/wb_bus_pkg.sv
hdl/aes_pkg.sv
hdl/aes_sbox.sv
hdl/aes_key_expand.sv
hdl/aes_round.sv
hdl/aes_128.sv
hdl/aes_top.sv
tests/tb_aes_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AES testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_aes_top --Mdir obj_dir -o tb_aes_top

./obj_dir/tb_aes_top > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
exit 0
